/* Makefile */
VERILATOR ?= verilator
TOP       ?= decoder_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG) || ! grep -q "TESTS PASSED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/decoder_pkg.sv */
`default_nettype none

package decoder_pkg;

    localparam int INSTR_WIDTH    = 32;
    localparam int DATA_BITS      = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // Instruction field positions
    localparam int RD_LSB     = 0;
    localparam int RS1_LSB    = 5;
    localparam int FUNCT3_LSB = 10;
    localparam int FUNCT4_LSB = 10;
    localparam int RS2_LSB    = 14;
    localparam int OPCODE_LSB = 29;

    typedef logic [INSTR_WIDTH-1:0]    instr_t;
    typedef logic [DATA_BITS-1:0]      data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Class field, code 6 is unused
    typedef enum logic [2:0] {
        OP_R      = 3'd0,
        OP_I      = 3'd1,
        OP_F      = 3'd2,
        OP_M      = 3'd3,
        OP_UP     = 3'd4,
        OP_SX_SLT = 3'd5,
        OP_J      = 3'd7
    } opcode_t;

    typedef enum logic [5:0] {
        NOP, ADD, SUB, MUL, DIV, SLT, SLL, SEQ, SNEZ, MIN, ABS,
        ADDI, MULI, DIVI, SLLI, SEQI,
        FADD, FSUB, FMUL, FDIV, FSLT, FNEG, FEQ, FMIN, FABS,
        FCVT_W_S, FCVT_S_W,
        JAL, BEQZ, BEQO
    } alu_op_t;

    typedef enum logic [1:0] {
        ALU_OUT,
        LSU_OUT,
        IMMEDIATE,
        VECTOR_TO_SCALAR
    } reg_src_t;

    typedef struct packed {
        logic [1:0] float_read;
        logic       float_write;
    } float_sel_t;

    typedef struct packed {
        logic       reg_write;
        logic       mem_read;
        logic       mem_write;
        logic       branch;
        logic       halt;
        logic       scalar;
        reg_src_t   reg_src;
        alu_op_t    alu_op;
        data_t      imm;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        float_sel_t float_sel;
        logic       illegal;
    } decoded_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_LOAD,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_fmt_t;

    typedef enum logic {
        IDLE,
        ACKED
    } decode_state_t;

    // All zero gives ALU_OUT and NOP
    localparam decoded_t DECODED_RESET = '0;

    function automatic opcode_t get_opcode(instr_t instr);
        return opcode_t'(instr[OPCODE_LSB +: 3]);
    endfunction

    function automatic reg_addr_t get_rd(instr_t instr);
        return instr[RD_LSB +: REG_ADDR_WIDTH];
    endfunction

    function automatic reg_addr_t get_rs1(instr_t instr);
        return instr[RS1_LSB +: REG_ADDR_WIDTH];
    endfunction

    function automatic reg_addr_t get_rs2(instr_t instr);
        return instr[RS2_LSB +: REG_ADDR_WIDTH];
    endfunction

    function automatic logic [2:0] get_funct3(instr_t instr);
        return instr[FUNCT3_LSB +: 3];
    endfunction

    function automatic logic [3:0] get_funct4(instr_t instr);
        return instr[FUNCT4_LSB +: 4];
    endfunction

endpackage

`default_nettype wire

/* decoder/alu_op_decode.sv */
`default_nettype none

module alu_op_decode (
    input  decoder_pkg::opcode_t    opcode,
    input  decoder_pkg::instr_t     instr,
    output decoder_pkg::alu_op_t    alu_op,
    output decoder_pkg::float_sel_t float_sel,
    output logic                    valid
);

    logic [3:0] funct4;
    logic [2:0] funct3;

    assign funct4 = decoder_pkg::get_funct4(instr);
    assign funct3 = decoder_pkg::get_funct3(instr);

    always_comb begin
        alu_op    = decoder_pkg::NOP;
        float_sel = '0;
        valid     = 1'b1;
        case (opcode)
            decoder_pkg::OP_R: begin
                case (funct4)
                    4'd0:    alu_op = decoder_pkg::ADD;
                    4'd1:    alu_op = decoder_pkg::SUB;
                    4'd2:    alu_op = decoder_pkg::MUL;
                    4'd3:    alu_op = decoder_pkg::DIV;
                    4'd4:    alu_op = decoder_pkg::SLT;
                    4'd5:    alu_op = decoder_pkg::SLL;
                    4'd6:    alu_op = decoder_pkg::SEQ;
                    4'd7:    alu_op = decoder_pkg::SNEZ;
                    4'd8:    alu_op = decoder_pkg::MIN;
                    4'd9:    alu_op = decoder_pkg::ABS;
                    default: valid  = 1'b0;
                endcase
            end
            decoder_pkg::OP_I: begin
                case (funct4)
                    4'd0:    alu_op = decoder_pkg::ADDI;
                    4'd2:    alu_op = decoder_pkg::MULI;
                    4'd3:    alu_op = decoder_pkg::DIVI;
                    4'd10:   alu_op = decoder_pkg::SLLI;
                    4'd11:   alu_op = decoder_pkg::SEQI;
                    default: valid  = 1'b0;
                endcase
            end
            decoder_pkg::OP_F: begin
                // Compares and float-to-int write the integer file
                case (funct4)
                    4'd0:    begin alu_op = decoder_pkg::FADD;     float_sel = 3'b111; end
                    4'd1:    begin alu_op = decoder_pkg::FSUB;     float_sel = 3'b111; end
                    4'd2:    begin alu_op = decoder_pkg::FMUL;     float_sel = 3'b111; end
                    4'd3:    begin alu_op = decoder_pkg::FDIV;     float_sel = 3'b111; end
                    4'd4:    begin alu_op = decoder_pkg::FSLT;     float_sel = 3'b110; end
                    4'd5:    begin alu_op = decoder_pkg::FNEG;     float_sel = 3'b011; end
                    4'd6:    begin alu_op = decoder_pkg::FEQ;      float_sel = 3'b110; end
                    4'd7:    begin alu_op = decoder_pkg::FMIN;     float_sel = 3'b111; end
                    4'd8:    begin alu_op = decoder_pkg::FABS;     float_sel = 3'b011; end
                    4'd9:    begin alu_op = decoder_pkg::FCVT_W_S; float_sel = 3'b010; end
                    4'd10:   begin alu_op = decoder_pkg::FCVT_S_W; float_sel = 3'b011; end
                    default: valid = 1'b0;
                endcase
            end
            decoder_pkg::OP_M: begin
                // Effective address is base plus offset
                alu_op = decoder_pkg::ADDI;
            end
            decoder_pkg::OP_SX_SLT: begin
                if (funct4 == 4'd0) begin
                    alu_op = decoder_pkg::SLT;
                end else begin
                    valid = 1'b0;
                end
            end
            decoder_pkg::OP_J: begin
                case (funct3)
                    3'd0:    alu_op = decoder_pkg::JAL;
                    3'd1:    alu_op = decoder_pkg::BEQZ;
                    3'd2:    alu_op = decoder_pkg::BEQO;
                    3'd7:    alu_op = decoder_pkg::NOP;  // EXIT
                    default: valid  = 1'b0;
                endcase
            end
            default: begin
                alu_op = decoder_pkg::NOP;
            end
        endcase
    end

endmodule

`default_nettype wire

/* decoder/control_decode.sv */
`default_nettype none

module control_decode (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    capture,
    input  decoder_pkg::instr_t     instr,
    input  decoder_pkg::data_t      imm,
    input  decoder_pkg::alu_op_t    alu_op,
    input  decoder_pkg::float_sel_t float_sel,
    input  logic                    op_valid,
    output decoder_pkg::imm_fmt_t   imm_fmt,
    output decoder_pkg::opcode_t    opcode,
    output decoder_pkg::decoded_t   decoded
);

    logic [2:0]            funct3;
    logic                  mem_ok;
    decoder_pkg::decoded_t rec;

    assign opcode = decoder_pkg::get_opcode(instr);
    assign funct3 = decoder_pkg::get_funct3(instr);

    // Immediate layout per class
    always_comb begin
        imm_fmt = decoder_pkg::IMM_NONE;
        case (opcode)
            decoder_pkg::OP_I:  imm_fmt = decoder_pkg::IMM_I;
            decoder_pkg::OP_M:  imm_fmt = funct3[0] ? decoder_pkg::IMM_S : decoder_pkg::IMM_LOAD;
            decoder_pkg::OP_UP: imm_fmt = decoder_pkg::IMM_U;
            decoder_pkg::OP_J: begin
                if (funct3 == 3'd0) begin
                    imm_fmt = decoder_pkg::IMM_J;
                end else if (funct3 == 3'd1 || funct3 == 3'd2) begin
                    imm_fmt = decoder_pkg::IMM_B;
                end
            end
            default: imm_fmt = decoder_pkg::IMM_NONE;
        endcase
    end

    always_comb begin
        rec           = decoder_pkg::DECODED_RESET;
        rec.alu_op    = alu_op;
        rec.float_sel = float_sel;
        rec.imm       = imm;
        mem_ok        = 1'b1;
        case (opcode)
            decoder_pkg::OP_R, decoder_pkg::OP_F: begin
                rec.rd        = decoder_pkg::get_rd(instr);
                rec.rs1       = decoder_pkg::get_rs1(instr);
                rec.rs2       = decoder_pkg::get_rs2(instr);
                rec.reg_write = 1'b1;
                rec.scalar    = instr[28];
            end
            decoder_pkg::OP_I: begin
                rec.rd        = decoder_pkg::get_rd(instr);
                rec.rs1       = decoder_pkg::get_rs1(instr);
                rec.reg_write = 1'b1;
                rec.scalar    = instr[28];
            end
            decoder_pkg::OP_M: begin
                rec.rs1    = decoder_pkg::get_rs1(instr);
                rec.scalar = instr[13];
                case (funct3)
                    3'd0, 3'd2: begin
                        // LW and FLW
                        rec.rd                    = decoder_pkg::get_rd(instr);
                        rec.reg_write             = 1'b1;
                        rec.reg_src               = decoder_pkg::LSU_OUT;
                        rec.mem_read              = 1'b1;
                        rec.float_sel.float_write = funct3[1];
                    end
                    3'd1, 3'd3: begin
                        // SW and FSW, store data may be float
                        rec.rs2                  = decoder_pkg::get_rs2(instr);
                        rec.mem_write            = 1'b1;
                        rec.float_sel.float_read = {funct3[1], 1'b0};
                    end
                    default: mem_ok = 1'b0;
                endcase
            end
            decoder_pkg::OP_UP: begin
                rec.rd        = decoder_pkg::get_rd(instr);
                rec.reg_write = 1'b1;
                rec.reg_src   = decoder_pkg::IMMEDIATE;
                rec.scalar    = instr[5];
            end
            decoder_pkg::OP_SX_SLT: begin
                rec.rd        = decoder_pkg::get_rd(instr);
                rec.rs1       = decoder_pkg::get_rs1(instr);
                rec.rs2       = decoder_pkg::get_rs2(instr);
                rec.reg_write = 1'b1;
                rec.reg_src   = decoder_pkg::VECTOR_TO_SCALAR;
            end
            decoder_pkg::OP_J: begin
                rec.scalar = 1'b1;
                if (funct3 == 3'd1 || funct3 == 3'd2) begin
                    rec.rs1    = decoder_pkg::get_rs1(instr);
                    rec.rs2    = decoder_pkg::get_rs2(instr);
                    rec.branch = 1'b1;
                end
                rec.halt = (funct3 == 3'd7);
            end
            default: begin
                // Unknown class decodes as a no-op
                rec = decoder_pkg::DECODED_RESET;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded <= decoder_pkg::DECODED_RESET;
        end else if (capture) begin
            if (!op_valid || !mem_ok) begin
                decoded         <= decoder_pkg::DECODED_RESET;
                decoded.illegal <= 1'b1;
            end else begin
                decoded <= rec;
            end
        end
    end

endmodule

`default_nettype wire

/* decoder/decode_ctrl.sv */
`default_nettype none

module decode_ctrl (
    input  logic clk,
    input  logic reset,
    input  logic req,
    output logic ack,
    output logic capture
);

    decoder_pkg::decode_state_t state;
    decoder_pkg::decode_state_t state_next;

    // Four-phase handshake, one decode per req pulse
    always_comb begin
        state_next = state;
        case (state)
            decoder_pkg::IDLE: begin
                if (req) begin
                    state_next = decoder_pkg::ACKED;
                end
            end
            decoder_pkg::ACKED: begin
                // Hold ack until the requester lets go
                if (!req) begin
                    state_next = decoder_pkg::IDLE;
                end
            end
            default: begin
                state_next = decoder_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= decoder_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Strobe only on the IDLE to ACKED step
    assign capture = (state == decoder_pkg::IDLE) && req;

    assign ack = (state == decoder_pkg::ACKED);

endmodule

`default_nettype wire

/* decoder/gpu_decoder.sv */
`default_nettype none

module gpu_decoder #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    output logic                  ack,
    input  decoder_pkg::instr_t   instr,
    output decoder_pkg::decoded_t decoded
);

    logic                    capture;
    logic                    op_valid;
    decoder_pkg::imm_fmt_t   imm_fmt;
    decoder_pkg::opcode_t    opcode;
    decoder_pkg::data_t      imm;
    decoder_pkg::alu_op_t    alu_op;
    decoder_pkg::float_sel_t float_sel;

    decode_ctrl u_decode_ctrl (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .ack     (ack),
        .capture (capture)
    );

    imm_gen #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_imm_gen (
        .instr (instr),
        .fmt   (imm_fmt),
        .imm   (imm)
    );

    alu_op_decode u_alu_op_decode (
        .opcode    (opcode),
        .instr     (instr),
        .alu_op    (alu_op),
        .float_sel (float_sel),
        .valid     (op_valid)
    );

    control_decode u_control_decode (
        .clk       (clk),
        .reset     (reset),
        .capture   (capture),
        .instr     (instr),
        .imm       (imm),
        .alu_op    (alu_op),
        .float_sel (float_sel),
        .op_valid  (op_valid),
        .imm_fmt   (imm_fmt),
        .opcode    (opcode),
        .decoded   (decoded)
    );

endmodule

`default_nettype wire

/* decoder/imm_gen.sv */
`default_nettype none

module imm_gen #(
    parameter int DATA_WIDTH = 32
) (
    input  decoder_pkg::instr_t   instr,
    input  decoder_pkg::imm_fmt_t fmt,
    output decoder_pkg::data_t    imm
);

    logic signed [13:0] i_field;
    logic signed [14:0] load_field;
    logic signed [14:0] s_field;
    logic signed [15:0] b_field;
    logic signed [25:0] j_field;
    logic        [31:0] u_field;
    logic [DATA_WIDTH-1:0] imm_wide;

    assign i_field    = instr[27:14];
    assign load_field = instr[28:14];
    assign s_field    = {instr[28:19], instr[4:0]};
    assign b_field    = {instr[28:19], instr[13], instr[4:0]};
    assign j_field    = {instr[28:13], instr[9:0]};

    // Upper immediate, low twelve bits cleared
    assign u_field = {instr[28:9], 12'b0};

    // Signed casts sign-extend to the datapath width
    always_comb begin
        imm_wide = '0;
        case (fmt)
            decoder_pkg::IMM_I:    imm_wide = DATA_WIDTH'(i_field);
            decoder_pkg::IMM_LOAD: imm_wide = DATA_WIDTH'(load_field);
            decoder_pkg::IMM_S:    imm_wide = DATA_WIDTH'(s_field);
            decoder_pkg::IMM_B:    imm_wide = DATA_WIDTH'(b_field);
            decoder_pkg::IMM_J:    imm_wide = DATA_WIDTH'(j_field);
            decoder_pkg::IMM_U:    imm_wide[31:0] = u_field;
            default:               imm_wide = '0;
        endcase
    end

    assign imm = imm_wide[decoder_pkg::DATA_BITS-1:0];

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
common/decoder_pkg.sv
decoder/decode_ctrl.sv
decoder/imm_gen.sv
decoder/alu_op_decode.sv
decoder/control_decode.sv
decoder/gpu_decoder.sv
test/decoder_tb.sv

/* test/decoder_ref.svh */
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

// Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic fb;
    fb = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], fb};
endfunction

function automatic decoder_pkg::data_t sign_extend(input decoder_pkg::data_t raw,
                                                   input int width);
    decoder_pkg::data_t result;
    result = raw;
    for (int i = width; i < 32; i++) begin
        result[i] = raw[width-1];
    end
    return result;
endfunction

// Operation per class, bad set on an unlisted code
function automatic decoder_pkg::alu_op_t ref_alu_op(input logic [2:0] cls,
                                                    input logic [3:0] f4,
                                                    input logic [2:0] f3,
                                                    output logic bad);
    decoder_pkg::alu_op_t op;
    op  = decoder_pkg::NOP;
    bad = 1'b0;
    case (cls)
        3'd0: begin
            case (f4)
                4'd0:    op = decoder_pkg::ADD;
                4'd1:    op = decoder_pkg::SUB;
                4'd2:    op = decoder_pkg::MUL;
                4'd3:    op = decoder_pkg::DIV;
                4'd4:    op = decoder_pkg::SLT;
                4'd5:    op = decoder_pkg::SLL;
                4'd6:    op = decoder_pkg::SEQ;
                4'd7:    op = decoder_pkg::SNEZ;
                4'd8:    op = decoder_pkg::MIN;
                4'd9:    op = decoder_pkg::ABS;
                default: bad = 1'b1;
            endcase
        end
        3'd1: begin
            case (f4)
                4'd0:    op = decoder_pkg::ADDI;
                4'd2:    op = decoder_pkg::MULI;
                4'd3:    op = decoder_pkg::DIVI;
                4'd10:   op = decoder_pkg::SLLI;
                4'd11:   op = decoder_pkg::SEQI;
                default: bad = 1'b1;
            endcase
        end
        3'd2: begin
            case (f4)
                4'd0:    op = decoder_pkg::FADD;
                4'd1:    op = decoder_pkg::FSUB;
                4'd2:    op = decoder_pkg::FMUL;
                4'd3:    op = decoder_pkg::FDIV;
                4'd4:    op = decoder_pkg::FSLT;
                4'd5:    op = decoder_pkg::FNEG;
                4'd6:    op = decoder_pkg::FEQ;
                4'd7:    op = decoder_pkg::FMIN;
                4'd8:    op = decoder_pkg::FABS;
                4'd9:    op = decoder_pkg::FCVT_W_S;
                4'd10:   op = decoder_pkg::FCVT_S_W;
                default: bad = 1'b1;
            endcase
        end
        3'd3: op = decoder_pkg::ADDI;
        3'd5: begin
            if (f4 == 4'd0) begin
                op = decoder_pkg::SLT;
            end else begin
                bad = 1'b1;
            end
        end
        3'd7: begin
            case (f3)
                3'd0:    op = decoder_pkg::JAL;
                3'd1:    op = decoder_pkg::BEQZ;
                3'd2:    op = decoder_pkg::BEQO;
                3'd7:    op = decoder_pkg::NOP;
                default: bad = 1'b1;
            endcase
        end
        default: op = decoder_pkg::NOP;
    endcase
    return op;
endfunction

function automatic decoder_pkg::float_sel_t ref_float_sel(input decoder_pkg::alu_op_t op);
    decoder_pkg::float_sel_t fs;
    fs = '0;
    case (op)
        decoder_pkg::FADD, decoder_pkg::FSUB, decoder_pkg::FMUL, decoder_pkg::FDIV,
        decoder_pkg::FMIN, decoder_pkg::FSLT, decoder_pkg::FEQ: begin
            fs.float_read = 2'b11;
        end
        decoder_pkg::FNEG, decoder_pkg::FABS, decoder_pkg::FCVT_W_S,
        decoder_pkg::FCVT_S_W: begin
            fs.float_read = 2'b01;
        end
        default: fs.float_read = 2'b00;
    endcase
    // Compares and float-to-int land in the integer file
    fs.float_write = (fs.float_read != 2'b00) && (op != decoder_pkg::FSLT)
                     && (op != decoder_pkg::FEQ) && (op != decoder_pkg::FCVT_W_S);
    return fs;
endfunction

function automatic decoder_pkg::decoded_t ref_decode(input decoder_pkg::instr_t word);
    decoder_pkg::decoded_t  d;
    decoder_pkg::reg_addr_t rd;
    decoder_pkg::reg_addr_t rs1;
    decoder_pkg::reg_addr_t rs2;
    logic [2:0]             cls;
    logic [3:0]             f4;
    logic [2:0]             f3;
    logic                   bad;
    d   = '0;
    cls = word[31:29];
    f4  = word[decoder_pkg::FUNCT4_LSB +: 4];
    f3  = word[decoder_pkg::FUNCT3_LSB +: 3];
    rd  = word[decoder_pkg::RD_LSB +: decoder_pkg::REG_ADDR_WIDTH];
    rs1 = word[decoder_pkg::RS1_LSB +: decoder_pkg::REG_ADDR_WIDTH];
    rs2 = word[decoder_pkg::RS2_LSB +: decoder_pkg::REG_ADDR_WIDTH];
    d.alu_op    = ref_alu_op(cls, f4, f3, bad);
    d.float_sel = ref_float_sel(d.alu_op);
    case (cls)
        3'd0, 3'd2: begin
            d.reg_write = 1'b1;
            d.scalar    = word[28];
            d.rd        = rd;
            d.rs1       = rs1;
            d.rs2       = rs2;
        end
        3'd1: begin
            d.reg_write = 1'b1;
            d.scalar    = word[28];
            d.rd        = rd;
            d.rs1       = rs1;
            d.imm       = sign_extend(decoder_pkg::data_t'(word[27:14]), 14);
        end
        3'd3: begin
            d.rs1    = rs1;
            d.scalar = word[13];
            if (f3[0]) begin
                d.imm = sign_extend(decoder_pkg::data_t'({word[28:19], word[4:0]}), 15);
            end else begin
                d.imm = sign_extend(decoder_pkg::data_t'(word[28:14]), 15);
            end
            if (f3 == 3'd0 || f3 == 3'd2) begin
                d.rd                    = rd;
                d.reg_write             = 1'b1;
                d.reg_src               = decoder_pkg::LSU_OUT;
                d.mem_read              = 1'b1;
                d.float_sel.float_write = f3[1];
            end else if (f3 == 3'd1 || f3 == 3'd3) begin
                d.rs2                  = rs2;
                d.mem_write            = 1'b1;
                d.float_sel.float_read = {f3[1], 1'b0};
            end else begin
                bad = 1'b1;
            end
        end
        3'd4: begin
            d.rd        = rd;
            d.reg_write = 1'b1;
            d.reg_src   = decoder_pkg::IMMEDIATE;
            d.scalar    = word[5];
            d.imm       = {word[28:9], 12'b0};
        end
        3'd5: begin
            d.rd        = rd;
            d.rs1       = rs1;
            d.rs2       = rs2;
            d.reg_write = 1'b1;
            d.reg_src   = decoder_pkg::VECTOR_TO_SCALAR;
        end
        3'd7: begin
            d.scalar = 1'b1;
            d.halt   = (f3 == 3'd7);
            if (f3 == 3'd0) begin
                d.imm = sign_extend(decoder_pkg::data_t'({word[28:13], word[9:0]}), 26);
            end else if (f3 == 3'd1 || f3 == 3'd2) begin
                d.rs1    = rs1;
                d.rs2    = rs2;
                d.branch = 1'b1;
                d.imm    = sign_extend(
                    decoder_pkg::data_t'({word[28:19], word[13], word[4:0]}), 16);
            end
        end
        default: d = '0;
    endcase
    if (bad) begin
        d         = '0;
        d.illegal = 1'b1;
    end
    return d;
endfunction

`endif

/* test/decoder_tb.sv */
`default_nettype none

module decoder_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int DRIVE_DELAY = 2;
    localparam int HS_LIMIT    = 4;
    localparam int NUM_RANDOM  = 200;
    // Four class sweeps, memory and jump codes, upper and unused classes
    localparam int NUM_TXN     = 64 + 16 + 16 + 4 + 4 + NUM_RANDOM;

    logic                  clk;
    logic                  reset;
    logic                  req;
    logic                  ack;
    decoder_pkg::instr_t   instr;
    decoder_pkg::decoded_t decoded;

    logic [15:0]           lfsr = 16'd50;
    decoder_pkg::instr_t   pending[$];
    int                    check_count    = 0;
    int                    mismatch_count = 0;
    int                    other_errors   = 0;

    `include "decoder_ref.svh"

    gpu_decoder #(
        .DATA_WIDTH (32)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .ack     (ack),
        .instr   (instr),
        .decoded (decoded)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_decoded(input decoder_pkg::decoded_t act,
                                 input decoder_pkg::decoded_t exp,
                                 input decoder_pkg::instr_t word);
        check_count++;
        if (act !== exp) begin
            $display("Mismatch decoded: instr %h got %h expected %h", word, act, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_alu_op(input decoder_pkg::alu_op_t act,
                                input decoder_pkg::alu_op_t exp,
                                input decoder_pkg::instr_t word);
        check_count++;
        if (act !== exp) begin
            $display("Mismatch alu_op: instr %h got %h expected %h", word, act, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_imm(input decoder_pkg::data_t act,
                             input decoder_pkg::data_t exp,
                             input decoder_pkg::instr_t word);
        check_count++;
        if (act !== exp) begin
            $display("Mismatch imm: instr %h got %h expected %h", word, act, exp);
            mismatch_count++;
        end
    endtask

    task automatic check_ack(input logic act, input logic exp);
        check_count++;
        if (act !== exp) begin
            $display("Mismatch ack: got %h expected %h", act, exp);
            mismatch_count++;
        end
    endtask

    // One LFSR step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Entered and left 2 units after a rising edge
    task automatic run_txn(input decoder_pkg::instr_t word);
        int          cycles;
        logic [31:0] hold;
        logic [31:0] junk;
        instr = word;
        req   = 1'b1;
        pending.push_back(word);
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (!ack && cycles < HS_LIMIT);
        if (!ack) begin
            $display("ack did not rise within %0d cycles of req", HS_LIMIT);
            other_errors++;
        end else if (cycles != 1) begin
            $display("ack rose %0d cycles after req instead of 1", cycles);
            other_errors++;
        end
        #(DRIVE_DELAY - 1);
        // Data is free to change once ack is up
        draw_bits(32, junk);
        instr = junk;
        // Requester holds req a while longer
        draw_bits(2, hold);
        repeat (hold) begin
            @(posedge clk);
            #1;
            check_ack(ack, 1'b1);
            #(DRIVE_DELAY - 1);
        end
        req    = 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            #1;
            cycles++;
        end while (ack && cycles < HS_LIMIT);
        if (ack) begin
            $display("ack stayed high %0d cycles after req fell", HS_LIMIT);
            other_errors++;
        end else if (cycles != 1) begin
            $display("ack fell %0d cycles after req instead of 1", cycles);
            other_errors++;
        end
        #(DRIVE_DELAY - 1);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic send_random(input logic [2:0] cls);
        logic [31:0] r;
        draw_bits(32, r);
        r[31:29] = cls;
        run_txn(r);
    endtask

    task automatic sweep_funct4(input logic [2:0] cls);
        logic [31:0] r;
        for (int f = 0; f < 16; f++) begin
            draw_bits(32, r);
            r[31:29] = cls;
            r[decoder_pkg::FUNCT4_LSB +: 4] = 4'(f);
            run_txn(r);
        end
    endtask

    task automatic sweep_funct3(input logic [2:0] cls);
        logic [31:0] r;
        for (int f = 0; f < 16; f++) begin
            draw_bits(32, r);
            r[31:29] = cls;
            // Both signs of every immediate
            r[28] = f[3];
            r[decoder_pkg::FUNCT3_LSB +: 3] = 3'(f);
            run_txn(r);
        end
    endtask

    // Checks each capture and then that decoded holds until the next one
    initial begin : compare_proc
        decoder_pkg::instr_t   word;
        decoder_pkg::decoded_t exp;
        logic                  ack_prev;
        logic                  have_last;
        word      = '0;
        exp       = '0;
        ack_prev  = 1'b0;
        have_last = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (ack && !ack_prev && pending.size() > 0) begin
                word = pending.pop_front();
                exp  = ref_decode(word);
                check_decoded(decoded, exp, word);
                check_alu_op(decoded.alu_op, exp.alu_op, word);
                check_imm(decoded.imm, exp.imm, word);
                have_last = 1'b1;
            end else if (have_last) begin
                check_decoded(decoded, exp, word);
            end
            ack_prev = ack;
        end
    end

    initial begin : watchdog
        #(NUM_TXN * 10 * CLK_PERIOD);
        $display("Watchdog timeout, run exceeded the time for %0d transactions", NUM_TXN);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main_proc
        reset = 1'b1;
        req   = 1'b0;
        instr = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        check_ack(ack, 1'b0);
        check_decoded(decoded, '0, instr);

        sweep_funct4(3'd0);
        sweep_funct4(3'd1);
        sweep_funct4(3'd2);
        sweep_funct4(3'd5);
        sweep_funct3(3'd3);
        sweep_funct3(3'd7);
        repeat (4) send_random(3'd4);
        repeat (4) send_random(3'd6);
        // Class steered round robin
        for (int i = 0; i < NUM_RANDOM; i++) begin
            send_random(3'(i % 8));
        end

        repeat (2) @(posedge clk);
        if (pending.size() != 0) begin
            $display("%0d requests were never acknowledged", pending.size());
            other_errors++;
        end
        $display("Summary: %0d checks, %0d mismatches, %0d other errors",
                 check_count, mismatch_count, other_errors);
        if (mismatch_count + other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
